// ==== fpAdder.f ====
hw/fpAddPkg.sv
hw/fpAlign.sv
hw/alignFifo.sv
hw/fpNormalize.sv
hw/fpAdder.sv
verification/fpAdderTb.sv

// ==== Makefile ====
LOG = sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f fpAdder.f --top-module fpAdderTb -o fpAdderSim

run: build
	./obj_dir/fpAdderSim | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then exit 1; fi
	@grep -q "TEST PASSED" $(LOG)

lint:
	verilator --lint-only --timing -f fpAdder.f --top-module fpAdder

clean:
	rm -rf obj_dir $(LOG)

// ==== verification/fpAdderTb.sv ====
// Testbench for the binary32 adder with stimulus, reference model, scoreboard and timeout
`default_nettype none

module fpAdderTb;
    timeunit 1ns;
    timeprecision 1ps;
    import fpAddPkg::*;

    localparam int numRandom     = 300;
    localparam int numCancel     = 40;
    localparam int numSpecial    = 12;
    localparam int numBack       = 60;
    localparam int totalOps      = numRandom + numCancel + numSpecial + numBack + fifoDepth + 2;
    localparam int timeoutCycles = 8 * totalOps + 200;

    logic        clk;
    logic        arstN;
    floatT       opA;
    floatT       opB;
    logic        opValid;
    logic        opReady;
    floatT       result;
    logic        resValid;
    logic        resReady;
    logic [31:0] expQ [$];              // Expected results in acceptance order
    logic [31:0] expected;
    integer      seed;
    int          errorCount;
    int          issueCount;
    int          resultCount;
    int          cycleCount;
    logic        stallMode;             // Random sink stalls

    fpAdder i_dut (.*);

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Zero exponent reads as zero
    function automatic real toReal(input floatT f);
        if (f.exponent == 8'h00)
            return 0.0;
        return $bitstoreal({f.sign, 11'(f.exponent) + 11'd896, f.mantissa, 29'b0});
    endfunction

    // Exact double rounded to binary32 with ties to even and flush below the normal range
    function automatic logic [31:0] roundToFloat(input real r);
        logic [63:0] bits;
        logic [24:0] man;
        logic        up;
        int          expo;
        if (r == 0.0)
            return 32'h0000_0000;       // Any zero sum is positive
        bits = $realtobits(r);
        expo = int'(bits[62:52]) - 896;
        if (expo < 1)
            return {bits[63], 31'b0};
        up  = bits[28] & ((|bits[27:0]) | bits[29]);
        man = {2'b01, bits[51:29]} + 25'(up);
        if (man[24])
            expo = expo + 1;
        if (expo >= 255)
            return {bits[63], 8'hFF, 23'h0};
        return {bits[63], 8'(expo), man[24] ? 23'h0 : man[22:0]};
    endfunction

    function automatic logic [31:0] refAdd(input floatT a, input floatT b);
        logic nanA;
        logic nanB;
        logic infA;
        logic infB;
        nanA = a.exponent == 8'hFF && a.mantissa != 23'h0;
        nanB = b.exponent == 8'hFF && b.mantissa != 23'h0;
        infA = a.exponent == 8'hFF && a.mantissa == 23'h0;
        infB = b.exponent == 8'hFF && b.mantissa == 23'h0;
        if (nanA)
            return a;
        if (nanB)
            return b;
        if (infA && infB)
            return (a.sign == b.sign) ? a : 32'h7FFF_FFFF;
        if (infA)
            return a;
        if (infB)
            return b;
        return roundToFloat(toReal(a) + toReal(b));
    endfunction

    task automatic stepCycle();
        integer r;
        @(posedge clk);
        #2;
        r = $random(seed);
        if (stallMode)
            resReady = r[0];
    endtask

    task automatic issueOp(input floatT a, input floatT b);
        logic taken;
        opA     = a;
        opB     = b;
        opValid = 1'b1;
        expQ.push_back(refAdd(a, b));
        issueCount++;
        taken = 1'b0;
        while (!taken)
        begin
            taken = opReady;            // Stable mid-cycle and valid for the next edge
            stepCycle();
        end
        opValid = 1'b0;
    endtask

    // Normal operands with exponents at most 20 apart
    task automatic randomPair(output floatT a, output floatT b);
        logic [31:0] r1;
        logic [31:0] r2;
        logic [31:0] r3;
        int          ea;
        int          eb;
        r1 = $random(seed);
        r2 = $random(seed);
        r3 = $random(seed);
        ea = 21 + int'(r1[15:0] % 213);
        eb = ea + int'(r1[31:16] % 41) - 20;
        a  = {r2[31], 8'(ea), r2[22:0]};
        b  = {r3[31], 8'(eb), r3[22:0]};
    endtask

    task automatic drain();
        while (expQ.size() != 0)
            stepCycle();
    endtask

    // Transfer happens at the coming rising edge
    always @(negedge clk)
    begin
        if (arstN && resValid && resReady)
        begin
            if (expQ.size() == 0)
            begin
                errorCount++;
                $display("Result %h arrived with no operation outstanding", result);
            end
            else
            begin
                expected = expQ.pop_front();
                resultCount++;
                assert (result === expected)
                else
                begin
                    errorCount++;
                    $display("** Error: result = %h, expected %h", result, expected);
                end
            end
        end
    end

    aResultHeld: assert property (@(posedge clk) disable iff (!arstN)
        resValid && !resReady |=> resValid && $stable(result))
    else
    begin
        errorCount++;
        $display("Result %h changed or was dropped while the sink stalled", result);
    end

    initial
    begin
        cycleCount = 0;
        while (cycleCount < timeoutCycles)
        begin
            @(posedge clk);
            cycleCount++;
        end
        $display("Timeout after %0d cycles with %0d of %0d results received",
                 cycleCount, resultCount, issueCount);
        $display("TEST FAILED");
        $finish;
    end

    initial
    begin
        floatT  a;
        floatT  b;
        int     i;
        integer r;
        seed        = 32'hae7f6aba;
        errorCount  = 0;
        issueCount  = 0;
        resultCount = 0;
        stallMode   = 1'b0;
        arstN       = 1'b0;
        opA         = '0;
        opB         = '0;
        opValid     = 1'b0;
        resReady    = 1'b1;
        repeat (2) @(posedge clk);
        #2;
        arstN = 1'b1;
        stepCycle();

        assert (!resValid)
        else
        begin
            errorCount++;
            $display("** Error: resValid = %h, expected 0", resValid);
        end
        assert (opReady)
        else
        begin
            errorCount++;
            $display("** Error: opReady = %h, expected 1", opReady);
        end

        for (i = 0; i < numRandom; i++)
        begin
            randomPair(a, b);
            issueOp(a, b);
        end

        // Exact cancel, near cancel, deep renormalize, flush to zero
        for (i = 0; i < numCancel / 4; i++)
        begin
            randomPair(a, b);
            r = $random(seed);
            issueOp(a, {~a.sign, a.exponent, a.mantissa});
            issueOp(a, {~a.sign, a.exponent, a.mantissa ^ 23'(r[7:0])});
            issueOp({a.sign, a.exponent, 23'(r[13:8])},
                    {~a.sign, a.exponent - 8'd1, ~23'(r[18:14])});
            issueOp({a.sign, 8'(r[21:20]) + 8'd1, a.mantissa},
                    {~a.sign, 8'(r[21:20]) + 8'd1, a.mantissa ^ (23'(r[25:22]) + 23'd1)});
        end

        issueOp(32'h7F7F_FFFF, 32'h7F7F_FFFF);   // Overflow
        issueOp(32'hFF7F_FFFF, 32'hFF00_0000);
        issueOp(32'h7F7F_FFFF, 32'h7300_0000);   // Rounding carries into Inf
        issueOp(32'h7FC0_0123, 32'hFFA0_0456);   // Two NaNs
        issueOp(32'h3F80_0000, 32'h7F80_0001);
        issueOp(32'hFFC0_0000, 32'h7F80_0000);
        issueOp(32'h7F80_0000, 32'h7FA0_0000);
        issueOp(32'h7F80_0000, 32'h7F80_0000);
        issueOp(32'hFF80_0000, 32'hFF80_0000);
        issueOp(32'h7F80_0000, 32'hFF80_0000);   // Inf minus Inf
        issueOp(32'hFF80_0000, 32'h4000_0000);
        issueOp(32'h4060_0000, 32'h7F80_0000);
        drain();

        // Output register plus a full FIFO
        resReady = 1'b0;
        for (i = 0; i < fifoDepth + 1; i++)
        begin
            randomPair(a, b);
            issueOp(a, b);
        end
        repeat (2) stepCycle();
        assert (!opReady)
        else
        begin
            errorCount++;
            $display("** Error: opReady = %h, expected 0", opReady);
        end
        resReady = 1'b1;
        stepCycle();
        assert (opReady)
        else
        begin
            errorCount++;
            $display("** Error: opReady = %h, expected 1", opReady);
        end
        randomPair(a, b);
        issueOp(a, b);

        stallMode = 1'b1;
        for (i = 0; i < numBack; i++)
        begin
            randomPair(a, b);
            issueOp(a, b);
        end
        drain();
        stallMode = 1'b0;
        resReady  = 1'b1;
        repeat (4) stepCycle();

        if (resultCount != issueCount)
        begin
            errorCount++;
            $display("Received %0d results for %0d operations", resultCount, issueCount);
        end
        $display("Results checked: %0d, errors: %0d", resultCount, errorCount);
        if (errorCount == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== hw/fpAdder.sv ====
// Top level of the pipelined binary32 adder with align stage, FIFO and normalize stage
`default_nettype none

module fpAdder
(
    input  logic           clk,
    input  logic           arstN,
    input  fpAddPkg::floatT opA,
    input  fpAddPkg::floatT opB,
    input  logic           opValid,
    output logic           opReady,
    output fpAddPkg::floatT result,
    output logic           resValid,
    input  logic           resReady
);
    import fpAddPkg::*;

    logic    alignedValid;
    alignedT aligned;
    alignedT fifoData;
    logic    fifoNotEmpty;
    logic    fifoPop;
    logic    creditReturn;

    fpAlign u_align
    (
        .clk          (clk),
        .arstN        (arstN),
        .opA          (opA),
        .opB          (opB),
        .opValid      (opValid),
        .opReady      (opReady),
        .creditReturn (creditReturn),
        .alignedValid (alignedValid),
        .aligned      (aligned)
    );

    // Room is guaranteed by credits so there is no ready
    alignFifo u_fifo
    (
        .clk          (clk),
        .arstN        (arstN),
        .pushValid    (alignedValid),
        .pushData     (aligned),
        .pop          (fifoPop),
        .headData     (fifoData),
        .notEmpty     (fifoNotEmpty),
        .creditReturn (creditReturn)
    );

    fpNormalize u_normalize
    (
        .clk          (clk),
        .arstN        (arstN),
        .fifoData     (fifoData),
        .fifoNotEmpty (fifoNotEmpty),
        .fifoPop      (fifoPop),
        .result       (result),
        .resValid     (resValid),
        .resReady     (resReady)
    );

endmodule

`default_nettype wire

// ==== hw/fpNormalize.sv ====
// Normalize stage with leading-zero shift, carry, overflow, specials and round to nearest even
`default_nettype none

module fpNormalize
(
    input  logic             clk,
    input  logic             arstN,
    input  fpAddPkg::alignedT fifoData,
    input  logic             fifoNotEmpty,
    output logic             fifoPop,
    output fpAddPkg::floatT   result,
    output logic             resValid,
    input  logic             resReady
);
    import fpAddPkg::*;

    logic [25:0]       normIn;
    logic [25:0]       normShifted;
    logic [4:0]        lz;
    logic [8:0]        preExp;
    logic [manWidth:0] preMan;
    logic              guard;
    logic              rest;
    logic              roundUp;
    logic [24:0]       rounded;
    logic [8:0]        finalExp;
    logic              nanA;
    logic              nanB;
    logic              infA;
    logic              infB;
    floatT             nextResult;

    // Leading zeros of sum plus guard and round
    function automatic logic [4:0] countZeros(input logic [25:0] value);
        logic [4:0] zeros;
        zeros = 5'd26;
        for (int i = 0; i < 26; i++)
        begin
            if (value[i])
                zeros = 5'(25 - i);     // Highest set bit wins
        end
        return zeros;
    endfunction

    assign nanA = fifoData.opA.exponent == expMax && fifoData.opA.mantissa != '0;
    assign nanB = fifoData.opB.exponent == expMax && fifoData.opB.mantissa != '0;
    assign infA = fifoData.opA.exponent == expMax && fifoData.opA.mantissa == '0;
    assign infB = fifoData.opB.exponent == expMax && fifoData.opB.mantissa == '0;

    always_comb
    begin
        normIn      = {fifoData.sum, fifoData.guardBit, fifoData.roundBit};
        lz          = countZeros(normIn);
        normShifted = normIn << lz;

        if (fifoData.carryOut)
        begin
            // One step right
            preExp = {1'b0, fifoData.exponent} + 9'd1;
            preMan = {1'b1, fifoData.sum[manWidth:1]};
            guard  = fifoData.sum[0];
            rest   = fifoData.guardBit | fifoData.roundBit | fifoData.stickyBit;
        end
        else
        begin
            preExp = {1'b0, fifoData.exponent} - {4'b0, lz};   // Wraps on underflow
            preMan = normShifted[25:2];
            guard  = normShifted[1];
            rest   = normShifted[0] | fifoData.stickyBit;
        end

        roundUp  = guard & (rest | preMan[0]);               // Ties go to even
        rounded  = {1'b0, preMan} + {24'b0, roundUp};
        finalExp = preExp + {8'b0, rounded[24]};             // All-ones mantissa wrapped

        if (fifoData.special)
        begin
            if (nanA)
                nextResult = fifoData.opA;
            else if (nanB)
                nextResult = fifoData.opB;
            else if (infA && infB)
                nextResult = (fifoData.opA.sign == fifoData.opB.sign) ? fifoData.opA
                                                                      : defaultNan;
            else if (infA)
                nextResult = fifoData.opA;
            else
                nextResult = fifoData.opB;
        end
        else if (!fifoData.carryOut && normIn == '0)
            nextResult = '0;                                 // Positive zero
        else if (!fifoData.carryOut && {1'b0, fifoData.exponent} <= {4'b0, lz})
            nextResult = '{sign: fifoData.sign, exponent: '0, mantissa: '0};  // Flush
        else if (finalExp >= 9'd255)
            nextResult = '{sign: fifoData.sign, exponent: expMax, mantissa: '0};
        else
            nextResult = '{sign: fifoData.sign, exponent: finalExp[7:0],
                           mantissa: rounded[manWidth-1:0]};
    end

    // Pop when the output register is free or draining
    assign fifoPop = fifoNotEmpty && (!resValid || resReady);

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
            resValid <= 1'b0;
        else if (fifoPop)
            resValid <= 1'b1;
        else if (resReady)
            resValid <= 1'b0;
    end

    always_ff @(posedge clk)
    begin
        if (fifoPop)
            result <= nextResult;
    end

    aHoldWhileStalled: assert property (@(posedge clk) disable iff (!arstN)
        resValid && !resReady |=> resValid && $stable(result));

endmodule

`default_nettype wire

// ==== hw/alignFifo.sv ====
// Circular FIFO of aligned sums with a credit pulse on every pop
`default_nettype none

module alignFifo
(
    input  logic             clk,
    input  logic             arstN,
    input  logic             pushValid,
    input  fpAddPkg::alignedT pushData,
    input  logic             pop,
    output fpAddPkg::alignedT headData,
    output logic             notEmpty,
    output logic             creditReturn
);
    import fpAddPkg::*;

    alignedT                mem [fifoDepth];
    logic [ptrWidth-1:0]    wrPtr;
    logic [ptrWidth-1:0]    rdPtr;
    logic [creditWidth-1:0] count;
    logic                   popOk;

    assign notEmpty     = count != '0;
    assign headData     = mem[rdPtr];
    assign popOk        = pop && notEmpty;
    assign creditReturn = popOk;            // Same cycle as the pop

    // Room is guaranteed by the align stage credits
    always_ff @(posedge clk)
    begin
        if (pushValid)
            mem[wrPtr] <= pushData;
    end

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end
        else
        begin
            if (pushValid)
                wrPtr <= (wrPtr == ptrWidth'(fifoDepth - 1)) ? '0 : wrPtr + 1'b1;
            if (popOk)
                rdPtr <= (rdPtr == ptrWidth'(fifoDepth - 1)) ? '0 : rdPtr + 1'b1;
            case ({pushValid, popOk})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Credits in flight must never outnumber free entries
    aNoPushFull: assert property (@(posedge clk) disable iff (!arstN)
        pushValid |-> count < creditWidth'(fifoDepth));

    aNoPopEmpty: assert property (@(posedge clk) disable iff (!arstN)
        pop |-> notEmpty);

endmodule

`default_nettype wire

// ==== hw/fpAlign.sv ====
// Align stage with unpack, exponent compare, alignment shift, mantissa add and credit counter
`default_nettype none

module fpAlign
(
    input  logic             clk,
    input  logic             arstN,
    input  fpAddPkg::floatT   opA,
    input  fpAddPkg::floatT   opB,
    input  logic             opValid,
    output logic             opReady,
    input  logic             creditReturn,
    output logic             alignedValid,
    output fpAddPkg::alignedT aligned
);
    import fpAddPkg::*;

    logic [manWidth:0]      manA;
    logic [manWidth:0]      manB;
    logic                   aGreater;
    floatT                  bigOp;
    floatT                  smallOp;
    logic [manWidth:0]      bigMan;
    logic [manWidth:0]      smallMan;
    logic [expWidth-1:0]    expDiff;
    logic [4:0]             shiftAmt;
    logic [49:0]            shiftWide;
    logic [26:0]            bigExt;
    logic [26:0]            smallExt;
    logic [27:0]            sumExt;
    logic                   subtract;
    alignedT                alignedNext;
    logic [creditWidth-1:0] credits;
    logic                   send;

    // Zero exponent means zero here including subnormals
    assign manA = (opA.exponent == '0) ? '0 : {1'b1, opA.mantissa};
    assign manB = (opB.exponent == '0) ? '0 : {1'b1, opB.mantissa};

    assign aGreater = {opA.exponent, manA} >= {opB.exponent, manB};
    assign bigOp    = aGreater ? opA : opB;
    assign smallOp  = aGreater ? opB : opA;
    assign bigMan   = aGreater ? manA : manB;
    assign smallMan = aGreater ? manB : manA;

    assign expDiff  = bigOp.exponent - smallOp.exponent;
    // Past 26 the shifted value only feeds sticky
    assign shiftAmt = (expDiff > 8'd26) ? 5'd26 : expDiff[4:0];

    always_comb
    begin
        shiftWide = {smallMan, 26'b0} >> shiftAmt;
        bigExt    = {bigMan, 3'b000};
        smallExt  = {shiftWide[49:24], |shiftWide[23:0]};  // Mantissa, G, R, S
        subtract  = opA.sign ^ opB.sign;

        if (subtract)
            sumExt = {1'b0, bigExt} - {1'b0, smallExt};  // Big minus small is never negative
        else
            sumExt = {1'b0, bigExt} + {1'b0, smallExt};

        alignedNext.sign      = (subtract && sumExt == '0) ? 1'b0 : bigOp.sign;
        alignedNext.exponent  = bigOp.exponent;
        alignedNext.sum       = sumExt[26:3];
        alignedNext.carryOut  = sumExt[27];
        alignedNext.guardBit  = sumExt[2];
        alignedNext.roundBit  = sumExt[1];
        alignedNext.stickyBit = sumExt[0];
        alignedNext.special   = (opA.exponent == expMax) || (opB.exponent == expMax);
        alignedNext.opA       = opA;
        alignedNext.opB       = opB;
    end

    // One credit per free FIFO entry
    assign opReady = credits != '0;
    assign send    = opValid && opReady;

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            credits      <= creditWidth'(fifoDepth);
            alignedValid <= 1'b0;
        end
        else
        begin
            alignedValid <= send;
            case ({send, creditReturn})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;     // Both or neither
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (send)
            aligned <= alignedNext;
    end

    aCreditMax: assert property (@(posedge clk) disable iff (!arstN)
        credits <= creditWidth'(fifoDepth));

endmodule

`default_nettype wire

// ==== hw/fpAddPkg.sv ====
// Float field widths, special constants, FIFO sizing and the float and aligned-sum structs
`default_nettype none

package fpAddPkg;

    localparam int expWidth = 8;
    localparam int manWidth = 23;

    localparam logic [expWidth-1:0] expMax = 8'hFF;   // Inf and NaN exponent

    // Binary32 as stored
    typedef struct packed {
        logic                sign;
        logic [expWidth-1:0] exponent;
        logic [manWidth-1:0] mantissa;
    } floatT;

    // Inf minus Inf
    localparam floatT defaultNan = '{sign: 1'b0, exponent: 8'hFF, mantissa: 23'h7FFFFF};

    localparam int fifoDepth   = 4;
    localparam int creditWidth = 3;                   // Holds 0 to fifoDepth
    localparam int ptrWidth    = $clog2(fifoDepth);

    // Output of the align stage
    typedef struct packed {
        logic                sign;
        logic [expWidth-1:0] exponent;                // Larger operand exponent
        logic [manWidth:0]   sum;                     // Includes implicit one
        logic                carryOut;
        logic                guardBit;
        logic                roundBit;
        logic                stickyBit;
        logic                special;                 // Some operand is Inf or NaN
        floatT               opA;
        floatT               opB;
    } alignedT;

endpackage

`default_nettype wire
